/* hdl/core_pkg.sv */
/*
 * core package
 * host-side definitions shared by the bridge registers,
 * the data table poller and the top level
 */
`default_nettype none

package core_pkg;

  // bridge address and data word
  typedef logic [31:0] bridge_word_t;
  // save-ram size code reported by the console
  typedef logic [3:0] sram_code_t;
  // data table address
  typedef logic [9:0] dt_addr_t;

  // one request on the host bridge
  typedef struct packed {
    bridge_word_t addr;
    logic         rd;
    logic         wr;
    bridge_word_t wr_data;
  } bridge_req_t;

  typedef struct packed {
    logic multitap_enabled;
    logic lightgun_enabled;
    logic lightgun_type;
  } core_settings_t;

  ////////////////////////////////////////
  // bridge register map
  localparam bridge_word_t addr_multitap = 32'h0000_0100;
  localparam bridge_word_t addr_lightgun = 32'h0000_0104;
  localparam bridge_word_t addr_rom_size = 32'h0000_0108;

  localparam bridge_word_t sram_unit_bytes = 32'd1024;

  // slot 0 size field, then size field of slot index 1 (index * 2 + 1)
  localparam dt_addr_t dt_rom_size_addr  = 10'd1;
  localparam dt_addr_t dt_save_size_addr = 10'd3;

endpackage

`default_nettype wire

/* hdl/video_pkg.sv */
/*
 * video package
 * pixel type and the raw and conditioned raster bundles
 */
`default_nettype none

package video_pkg;

  // 8 bits each of red, green and blue
  typedef logic [23:0] rgb_t;

  // raster as it leaves the console
  typedef struct packed {
    rgb_t rgb;
    logic hblank;
    logic vblank;
    logic hsync;
    logic vsync;
  } video_raw_t;

  // raster as the scaler wants it
  typedef struct packed {
    rgb_t rgb;
    logic de;
    logic hs;
    logic vs;
  } video_out_t;

endpackage

`default_nettype wire

/* hdl/core_settings_regs.sv */
/*
 * settings registers
 * holds multitap and lightgun settings written over the bridge
 * and returns them, plus the rom size, on bridge reads
 */
`timescale 1ns/1ns
`default_nettype none

module core_settings_regs (
  input  wire                     clk_74a,
  input  wire                     pll_core_locked,
  input  wire core_pkg::bridge_req_t  bridge_req,
  input  wire core_pkg::bridge_word_t rom_file_size,
  output core_pkg::core_settings_t    core_settings,
  output core_pkg::bridge_word_t      bridge_rd_data
);

  import core_pkg::*;

  ////////////////////////////////////////
  // register writes
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      core_settings <= '0;
    end else if (bridge_req.wr) begin
      if (bridge_req.addr == addr_multitap) begin
        core_settings.multitap_enabled <= bridge_req.wr_data[0];
      end else if (bridge_req.addr == addr_lightgun) begin
        core_settings.lightgun_enabled <= bridge_req.wr_data[0];
        core_settings.lightgun_type    <= bridge_req.wr_data[1];
      end
    end
  end

  ////////////////////////////////////////
  // read mux, zero latency
  always_comb begin
    case (bridge_req.addr)
      addr_multitap: begin
        bridge_rd_data = {31'b0, core_settings.multitap_enabled};
      end
      addr_lightgun: begin
        bridge_rd_data = {30'b0, core_settings.lightgun_type, core_settings.lightgun_enabled};
      end
      addr_rom_size: bridge_rd_data = rom_file_size;
      default:       bridge_rd_data = '0;
    endcase
  end

  // stray writes must leave the settings alone
  a_no_stray_write: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    (bridge_req.wr && bridge_req.addr != addr_multitap && bridge_req.addr != addr_lightgun)
      |=> $stable(core_settings)
  );

endmodule

`default_nettype wire

/* hdl/datatable_poller.sv */
/*
 * data table poller
 * shares the data table port between reading the rom file size
 * and publishing the save-ram byte size
 */
`timescale 1ns/1ns
`default_nettype none

module datatable_poller (
  input  wire                     clk_74a,
  input  wire                     pll_core_locked,
  input  wire core_pkg::sram_code_t   sram_code,
  input  wire core_pkg::bridge_word_t dt_rdata,
  output core_pkg::dt_addr_t          dt_addr,
  output logic                        dt_wren,
  output core_pkg::bridge_word_t      dt_wdata,
  output core_pkg::bridge_word_t      rom_file_size
);

  import core_pkg::*;

  logic [2:0]   phase;
  bridge_word_t save_bytes;

  // code 0 means no save ram at all
  assign save_bytes = (sram_code == '0) ? '0 : (sram_unit_bytes << sram_code);

  ////////////////////////////////////////
  // phase sequencer
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase         <= '0;
      dt_addr       <= '0;
      dt_wren       <= 1'b0;
      dt_wdata      <= '0;
      rom_file_size <= '0;
    end else begin
      phase <= phase + 3'd1;

      if (phase > 3'd4) begin
        // last three phases publish the save size
        dt_wren  <= 1'b1;
        dt_addr  <= dt_save_size_addr;
        dt_wdata <= save_bytes;
      end else begin
        dt_wren <= 1'b0;
        dt_addr <= dt_rom_size_addr;

        // read data has settled by now
        if (phase == 3'd4) begin
          rom_file_size <= dt_rdata;
        end
      end
    end
  end

  // writes only ever target the save size field
  a_write_addr: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    dt_wren |-> (dt_addr == dt_save_size_addr)
  );

endmodule

`default_nettype wire

/* hdl/dataslot_tracker.sv */
/*
 * data slot tracker
 * follows the host's slot requests to flag rom download
 * and save transfer activity
 */
`timescale 1ns/1ns
`default_nettype none

module dataslot_tracker (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  dataslot_request_read,
  input  wire  dataslot_request_write,
  input  wire  dataslot_all_complete,
  output logic rom_download,
  output logic save_transfer
);

  logic all_complete_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      all_complete_prev <= 1'b0;
      rom_download      <= 1'b0;
      save_transfer     <= 1'b0;
    end else begin
      all_complete_prev <= dataslot_all_complete;

      // set wins over clear
      if (dataslot_request_write) begin
        rom_download <= 1'b1;
      end else if (dataslot_all_complete) begin
        rom_download <= 1'b0;
      end

      // clear only on the rising edge of all_complete
      if (dataslot_request_read || dataslot_request_write) begin
        save_transfer <= 1'b1;
      end else if (dataslot_all_complete && !all_complete_prev) begin
        save_transfer <= 1'b0;
      end
    end
  end

  a_rom_download_cause: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(rom_download) |-> $past(dataslot_request_write)
  );

endmodule

`default_nettype wire

/* hdl/video_conditioner.sv */
/*
 * video conditioner
 * forms data enable, blanks pixels and turns each sync
 * into a single-cycle pulse for the scaler
 */
`timescale 1ns/1ns
`default_nettype none

module video_conditioner (
  input  wire                     clk_74a,
  input  wire                     pll_core_locked,
  input  wire video_pkg::video_raw_t video_raw,
  output video_pkg::video_out_t      video_out
);

  import video_pkg::*;

  logic hs_prev;
  logic vs_prev;
  logic de_next;
  rgb_t rgb_next;

  // visible only outside both blanking intervals
  assign de_next  = !(video_raw.hblank || video_raw.vblank);
  assign rgb_next = de_next ? video_raw.rgb : '0;

  ////////////////////////////////////////
  // output register
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_out.rgb <= rgb_next;
      video_out.de  <= de_next;
      // one pulse per rising sync edge
      video_out.hs  <= video_raw.hsync && !hs_prev;
      video_out.vs  <= video_raw.vsync && !vs_prev;
      hs_prev       <= video_raw.hsync;
      vs_prev       <= video_raw.vsync;
    end
  end

  a_hs_single: assert property (
    @(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.hs |=> !video_out.hs
  );

endmodule

`default_nettype wire

/* hdl/pocket_core.sv */
/*
 * pocket core top level
 * connects the settings registers, data table poller,
 * slot tracker and video conditioner to the host and console
 */
`timescale 1ns/1ns
`default_nettype none

module pocket_core (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  // host bridge
  input  wire core_pkg::bridge_req_t  bridge_req,
  output wire core_pkg::bridge_word_t bridge_rd_data,
  // data table port
  output wire core_pkg::dt_addr_t     dt_addr,
  output wire                         dt_wren,
  output wire core_pkg::bridge_word_t dt_wdata,
  input  wire core_pkg::bridge_word_t dt_rdata,
  // console side
  input  wire core_pkg::sram_code_t   sram_code,
  output wire core_pkg::core_settings_t core_settings,
  // slot pulses from the host
  input  wire                         dataslot_request_read,
  input  wire                         dataslot_request_write,
  input  wire                         dataslot_all_complete,
  output wire                         rom_download,
  output wire                         save_transfer,
  // raster
  input  wire video_pkg::video_raw_t  video_raw,
  output wire video_pkg::video_out_t  video_out
);

  import core_pkg::*;

  // captured by the poller, read back over the bridge
  wire bridge_word_t rom_file_size;

  ////////////////////////////////////////
  // host side
  core_settings_regs i_core_settings_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_req     (bridge_req),
    .rom_file_size  (rom_file_size),
    .core_settings  (core_settings),
    .bridge_rd_data (bridge_rd_data)
  );

  datatable_poller i_datatable_poller (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .sram_code      (sram_code),
    .dt_rdata       (dt_rdata),
    .dt_addr        (dt_addr),
    .dt_wren        (dt_wren),
    .dt_wdata       (dt_wdata),
    .rom_file_size  (rom_file_size)
  );

  dataslot_tracker i_dataslot_tracker (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_request_read (dataslot_request_read),
    .dataslot_request_write(dataslot_request_write),
    .dataslot_all_complete (dataslot_all_complete),
    .rom_download          (rom_download),
    .save_transfer         (save_transfer)
  );

  ////////////////////////////////////////
  // video side
  video_conditioner i_video_conditioner (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_raw      (video_raw),
    .video_out      (video_out)
  );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
/*
 * testbench clock and reset
 * 8 ns clock, reset held low for the first 8 cycles
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_74a,
  output logic pll_core_locked
);

  initial begin
    clk_74a = 1'b0;
    forever #4 clk_74a = ~clk_74a;
  end

  // release just after the 8th rising edge
  initial begin
    pll_core_locked = 1'b0;
    repeat (8) @(posedge clk_74a);
    #1 pll_core_locked = 1'b1;
  end

endmodule

`default_nettype wire

/* sim/tb_pocket_core.sv */
/*
 * pocket core testbench
 * applies a table of bridge, data table, slot and video steps
 * and checks the responses one step at a time
 */
`timescale 1ns/1ns
`default_nettype none

module tb_pocket_core;

  import core_pkg::*;
  import video_pkg::*;

  typedef enum logic [2:0] {
    op_none, op_write, op_read, op_slot, op_video, op_dt_hold, op_save
  } op_t;

  // one table row: operation, two operands, expected value
  typedef struct packed {
    op_t          op;
    bridge_word_t arg0;
    bridge_word_t arg1;
    bridge_word_t expected;
  } step_t;

  localparam int max_steps = 48;

  logic           clk_74a;
  logic           pll_core_locked;
  bridge_req_t    bridge_req;
  bridge_word_t   bridge_rd_data;
  dt_addr_t       dt_addr;
  logic           dt_wren;
  bridge_word_t   dt_wdata;
  bridge_word_t   dt_rdata;
  sram_code_t     sram_code;
  core_settings_t core_settings;
  logic           slot_read, slot_write, slot_complete;
  logic           rom_download, save_transfer;
  video_raw_t     video_raw;
  video_out_t     video_out;

  step_t       steps [max_steps];
  int          num_steps;
  int          check_count;
  int          error_count;
  int          cycle_limit;
  int          cycle_count;
  int          wren_seen;
  logic [31:0] rand_state;
  step_t       pending;
  rgb_t        pending_rgb;

  tb_clock_gen i_tb_clock_gen (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked)
  );

  pocket_core i_pocket_core (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .bridge_req            (bridge_req),
    .bridge_rd_data        (bridge_rd_data),
    .dt_addr               (dt_addr),
    .dt_wren               (dt_wren),
    .dt_wdata              (dt_wdata),
    .dt_rdata              (dt_rdata),
    .sram_code             (sram_code),
    .core_settings         (core_settings),
    .dataslot_request_read (slot_read),
    .dataslot_request_write(slot_write),
    .dataslot_all_complete (slot_complete),
    .rom_download          (rom_download),
    .save_transfer         (save_transfer),
    .video_raw             (video_raw),
    .video_out             (video_out)
  );

  ////////////////////////////////////////
  // helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // multi-cycle steps last arg1 cycles, the rest one cycle
  function automatic int table_cycles();
    int total;
    total = 1;
    for (int i = 0; i < num_steps; i++) begin
      total += (steps[i].op == op_dt_hold || steps[i].op == op_save) ? steps[i].arg1 : 1;
    end
    return total;
  endfunction

  task automatic add_step(input op_t op, input bridge_word_t a0, input bridge_word_t a1,
                          input bridge_word_t exp_value);
    steps[num_steps] = '{op: op, arg0: a0, arg1: a1, expected: exp_value};
    num_steps++;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_value,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === exp_value) else begin
      error_count++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp_value, actual);
    end
  endtask

  // strobes fall back to idle unless the step raises them
  task automatic drive_step(input step_t s);
    bridge_req.wr = 1'b0;
    bridge_req.rd = 1'b0;
    {slot_complete, slot_write, slot_read} = 3'b000;
    case (s.op)
      op_write: begin
        bridge_req.addr    = s.arg0;
        bridge_req.wr_data = s.arg1;
        bridge_req.wr      = 1'b1;
      end
      op_read: begin
        bridge_req.addr = s.arg0;
        bridge_req.rd   = 1'b1;
      end
      op_slot: {slot_complete, slot_write, slot_read} = s.arg0[2:0];
      op_video: begin
        rand_state    = xorshift32(rand_state);
        video_raw.rgb = rand_state[23:0];
        {video_raw.hblank, video_raw.vblank, video_raw.hsync, video_raw.vsync} = s.arg0[3:0];
      end
      op_dt_hold: dt_rdata = s.arg0;
      op_save:    sram_code = s.arg0[3:0];
      default: ;
    endcase
  endtask

  // results that show up one clock after the step
  task automatic check_registered(input step_t s, input rgb_t rgb);
    case (s.op)
      op_write: check_value("core_settings", s.expected, {29'b0, core_settings});
      op_slot: begin
        check_value("rom_download", s.expected[1], rom_download);
        check_value("save_transfer", s.expected[0], save_transfer);
      end
      op_video: begin
        check_value("video_out.de", s.expected[2], video_out.de);
        check_value("video_out.hs", s.expected[1], video_out.hs);
        check_value("video_out.vs", s.expected[0], video_out.vs);
        check_value("video_out.rgb", s.expected[2] ? rgb : 24'h0, video_out.rgb);
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////
  // stimulus table
  task automatic build_table();
    // settings written, read back, unmapped address ignored
    add_step(op_write, addr_multitap, 32'h1, 32'h4);
    add_step(op_write, addr_lightgun, 32'h3, 32'h7);
    add_step(op_read, addr_multitap, 32'h0, 32'h1);
    add_step(op_read, addr_lightgun, 32'h0, 32'h3);
    add_step(op_write, addr_lightgun, 32'h2, 32'h5);
    add_step(op_write, 32'h0000_0200, 32'h0, 32'h5);
    add_step(op_read, 32'h0000_0200, 32'h0, 32'h0);
    add_step(op_write, addr_multitap, 32'h0, 32'h1);
    add_step(op_read, addr_lightgun, 32'h0, 32'h2);
    // rom size captured from the data table
    add_step(op_dt_hold, 32'h0012_3456, 32'd10, 32'h0);
    add_step(op_read, addr_rom_size, 32'h0, 32'h0012_3456);
    add_step(op_dt_hold, 32'h8000_0400, 32'd10, 32'h0);
    add_step(op_read, addr_rom_size, 32'h0, 32'h8000_0400);
    // save size published for several codes
    add_step(op_save, 32'd0, 32'd16, 32'h0);
    add_step(op_save, 32'd3, 32'd16, 32'h0000_2000);
    add_step(op_save, 32'd7, 32'd16, 32'h0002_0000);
    add_step(op_save, 32'd15, 32'd16, 32'h0200_0000);
    // slot pulses {complete, write, read}, expected {rom_download, save_transfer}
    add_step(op_slot, 32'b010, 32'h0, 32'b11);
    add_step(op_slot, 32'b100, 32'h0, 32'b00);
    add_step(op_slot, 32'b101, 32'h0, 32'b01);
    add_step(op_slot, 32'b100, 32'h0, 32'b01);
    add_step(op_slot, 32'b100, 32'h0, 32'b01);
    add_step(op_slot, 32'b000, 32'h0, 32'b01);
    add_step(op_slot, 32'b100, 32'h0, 32'b00);
    add_step(op_slot, 32'b110, 32'h0, 32'b11);
    add_step(op_slot, 32'b100, 32'h0, 32'b01);
    // raw {hblank, vblank, hsync, vsync}, expected {de, hs, vs}
    add_step(op_video, 32'b0000, 32'h0, 32'b100);
    add_step(op_video, 32'b0010, 32'h0, 32'b110);
    add_step(op_video, 32'b1010, 32'h0, 32'b000);
    add_step(op_video, 32'b1010, 32'h0, 32'b000);
    add_step(op_video, 32'b0101, 32'h0, 32'b001);
    add_step(op_video, 32'b0111, 32'h0, 32'b010);
    add_step(op_video, 32'b0000, 32'h0, 32'b100);
    add_step(op_video, 32'b1100, 32'h0, 32'b000);
    add_step(op_video, 32'b0010, 32'h0, 32'b110);
  endtask

  ////////////////////////////////////////
  // main sequence
  initial begin
    bridge_req    = '0;
    dt_rdata      = '0;
    sram_code     = '0;
    slot_read     = 1'b0;
    slot_write    = 1'b0;
    slot_complete = 1'b0;
    video_raw     = '0;
    num_steps     = 0;
    check_count   = 0;
    error_count   = 0;
    rand_state    = 32'hdae4_3235;
    pending       = '0;
    pending_rgb   = '0;
    build_table();
    cycle_limit = 2 * table_cycles() + 64;

    @(posedge pll_core_locked);
    @(negedge clk_74a);
    check_value("core_settings", 32'h0, {29'b0, core_settings});
    check_value("rom_download", 32'h0, rom_download);
    check_value("save_transfer", 32'h0, save_transfer);
    check_value("dt_wren", 32'h0, dt_wren);
    check_value("video_out.de", 32'h0, video_out.de);
    check_value("video_out.hs", 32'h0, video_out.hs);
    check_value("video_out.vs", 32'h0, video_out.vs);

    for (int i = 0; i < num_steps; i++) begin
      @(posedge clk_74a);
      #1;
      drive_step(steps[i]);
      @(negedge clk_74a);
      check_registered(pending, pending_rgb);
      if (steps[i].op == op_read) begin
        check_value("bridge_rd_data", steps[i].expected, bridge_rd_data);
      end
      pending     = steps[i];
      pending_rgb = video_raw.rgb;

      if (steps[i].op == op_dt_hold || steps[i].op == op_save) begin
        // first cycle still carries the old size code
        wren_seen = 0;
        repeat (steps[i].arg1 - 1) begin
          @(negedge clk_74a);
          if (steps[i].op == op_save && dt_wren) begin
            wren_seen++;
            check_value("dt_addr", dt_save_size_addr, dt_addr);
            check_value("dt_wdata", steps[i].expected, dt_wdata);
          end
        end
        if (steps[i].op == op_save) begin
          check_count++;
          assert (wren_seen > 0) else begin
            error_count++;
            $display("no data table write seen for save size code %0d", steps[i].arg0);
          end
        end
      end
    end

    @(posedge clk_74a);
    #1;
    drive_step('0);
    @(negedge clk_74a);
    check_registered(pending, pending_rgb);

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // run limit in clock cycles
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_74a);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* pocket_core.f */
hdl/core_pkg.sv
hdl/video_pkg.sv
hdl/core_settings_regs.sv
hdl/datatable_poller.sv
hdl/dataslot_tracker.sv
hdl/video_conditioner.sv
hdl/pocket_core.sv
sim/tb_clock_gen.sv
sim/tb_pocket_core.sv
